// ==== hw/nf_cfg.svh ====
`ifndef NF_CFG_SVH
`define NF_CFG_SVH

// bus geometry
`define NF_DATA_WIDTH       32      // wishbone data width
`define NF_ADDR_WIDTH       32      // byte address width

// peripheral widths
`define NF_GPIO_WIDTH       8       // gpio pins
`define NF_PWM_WIDTH        8       // pwm counter and duty
`define NF_RAM_DEPTH        256     // ram words

// memory map, region select field
`define NF_REGION_LSB       12      // low bit of slave select
`define NF_REGION_MSB       15      // high bit of slave select
`define NF_REGION_RAM       0       // ram window
`define NF_REGION_GPIO      1       // gpio window
`define NF_REGION_PWM       2       // pwm window

// register byte offsets inside a region
`define NF_GPIO_GPI_OFS     'h0     // input pins
`define NF_GPIO_GPO_OFS     'h4     // output value
`define NF_GPIO_GPD_OFS     'h8     // direction
`define NF_PWM_DUTY_OFS     'h0     // duty value

`endif

// ==== hw/nf_pkg.sv ====
`include "nf_cfg.svh"

package nf_pkg;

    // bus side
    typedef logic   [`NF_ADDR_WIDTH-1     : 0]    addr_t;     // byte address
    typedef logic   [`NF_DATA_WIDTH-1     : 0]    data_t;     // bus data word
    typedef logic   [`NF_DATA_WIDTH/8-1   : 0]    sel_t;      // one bit per byte lane

    // peripheral side
    typedef logic   [`NF_GPIO_WIDTH-1     : 0]    gpio_t;     // gpio pin vector
    typedef logic   [`NF_PWM_WIDTH-1      : 0]    duty_t;     // pwm duty / counter

endpackage : nf_pkg

// ==== hw/nf_wb_decoder.sv ====
`timescale 1ns/1ps
`include "nf_cfg.svh"

module nf_wb_decoder
    import nf_pkg::*;
(
    // clock and reset
    input   logic   [0 : 0]     clk,            // clock
    input   logic   [0 : 0]     rst_n_i,        // async reset, active low
    // master side
    input   logic   [0 : 0]     wb_cyc_i,       // bus cycle
    input   logic   [0 : 0]     wb_stb_i,       // bus strobe
    input   addr_t              wb_adr_i,       // byte address
    // slave strobes
    output  logic   [0 : 0]     ram_stb_o,      // ram select
    output  logic   [0 : 0]     gpio_stb_o,     // gpio select
    output  logic   [0 : 0]     pwm_stb_o,      // pwm select
    // slave returns
    input   logic   [0 : 0]     ram_ack_i,      // ram ack
    input   logic   [0 : 0]     gpio_ack_i,     // gpio ack
    input   logic   [0 : 0]     pwm_ack_i,      // pwm ack
    input   data_t              ram_dat_i,      // ram read data
    input   data_t              gpio_dat_i,     // gpio read data
    input   data_t              pwm_dat_i,      // pwm read data
    // back to master
    output  data_t              wb_dat_o,       // muxed read data
    output  logic   [0 : 0]     wb_ack_o,       // any slave ack
    output  logic   [0 : 0]     wb_err_o        // unmapped access
);

    localparam  reg_w = `NF_REGION_MSB - `NF_REGION_LSB + 1;

    logic   [reg_w-1 : 0]   region;         // region of current request
    logic   [reg_w-1 : 0]   region_r;       // region of access being acked
    logic   [0 : 0]         req;            // valid request on the bus
    logic   [0 : 0]         unmapped;       // no slave behind region
    logic   [0 : 0]         err_r;          // error pulse

    assign req      = wb_cyc_i & wb_stb_i;
    assign region   = wb_adr_i[`NF_REGION_MSB : `NF_REGION_LSB];
    assign unmapped = (region != `NF_REGION_RAM) && (region != `NF_REGION_GPIO) &&
                      (region != `NF_REGION_PWM);

    // strobe steered to one slave only
    assign ram_stb_o  = req & (region == `NF_REGION_RAM);
    assign gpio_stb_o = req & (region == `NF_REGION_GPIO);
    assign pwm_stb_o  = req & (region == `NF_REGION_PWM);

    always_ff @(posedge clk, negedge rst_n_i) begin
        if (!rst_n_i) begin
            region_r <= '0;
            err_r    <= 1'b0;
        end else begin
            if (req) begin
                region_r <= region;             // held while master waits
            end
            err_r <= req & unmapped & ~err_r;   // same pulse shape as a slave ack
        end
    end

    assign wb_err_o = err_r;
    assign wb_ack_o = ram_ack_i | gpio_ack_i | pwm_ack_i;  // at most one slave active

    always_comb begin
        case (region_r)
            `NF_REGION_RAM  : wb_dat_o = ram_dat_i;
            `NF_REGION_GPIO : wb_dat_o = gpio_dat_i;
            `NF_REGION_PWM  : wb_dat_o = pwm_dat_i;
            default         : wb_dat_o = '0;    // err cycles read zero
        endcase
    end

endmodule : nf_wb_decoder

// ==== hw/nf_wb_ram.sv ====
`timescale 1ns/1ps
`include "nf_cfg.svh"

module nf_wb_ram
    import nf_pkg::*;
#(
    parameter   depth = `NF_RAM_DEPTH               // words
)
(
    // clock and reset
    input   logic   [0 : 0]     clk,                // clock
    input   logic   [0 : 0]     rst_n_i,            // async reset, active low
    // slave side
    input   logic   [0 : 0]     stb_i,              // select from decoder
    input   logic   [0 : 0]     we_i,               // write enable
    input   addr_t              adr_i,              // byte address
    input   data_t              dat_i,              // write data
    input   sel_t               sel_i,              // byte lanes
    output  data_t              dat_o,              // read data
    output  logic   [0 : 0]     ack_o               // one cycle ack
);

    localparam  idx_w = $clog2(depth),
                lanes = $bits(sel_t);

    data_t                  mem [depth];            // word storage
    logic   [idx_w-1 : 0]   widx;                   // word index
    logic   [0 : 0]         acc;                    // first cycle of an access

    assign widx = adr_i[idx_w+1 : 2];               // byte offset dropped, wraps at depth
    assign acc  = stb_i & ~ack_o;

    // storage and read port
    always_ff @(posedge clk) begin
        if (acc) begin
            if (we_i) begin
                for (int i = 0; i < lanes; i++) begin
                    if (sel_i[i]) begin
                        mem[widx][i*8 +: 8] <= dat_i[i*8 +: 8];    // lane write
                    end
                end
            end
            dat_o <= mem[widx];                     // old word on a write
        end
    end

    always_ff @(posedge clk, negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= acc;                           // drops after one cycle
        end
    end

endmodule : nf_wb_ram

// ==== hw/nf_wb_gpio.sv ====
`timescale 1ns/1ps
`include "nf_cfg.svh"

module nf_wb_gpio
    import nf_pkg::*;
#(
    parameter   gpio_w = `NF_GPIO_WIDTH                 // pin count
)
(
    // clock and reset
    input   logic   [0 : 0]         clk,                // clock
    input   logic   [0 : 0]         rst_n_i,            // async reset, active low
    // slave side
    input   logic   [0 : 0]         stb_i,              // select from decoder
    input   logic   [0 : 0]         we_i,               // write enable
    input   addr_t                  adr_i,              // byte address
    input   data_t                  dat_i,              // write data
    output  data_t                  dat_o,              // read data
    output  logic   [0 : 0]         ack_o,              // one cycle ack
    // pins
    input   logic   [gpio_w-1 : 0]  gpio_i,             // async input pins
    output  logic   [gpio_w-1 : 0]  gpio_o,             // output value
    output  logic   [gpio_w-1 : 0]  gpio_d_o            // direction, 1 = drive
);

    localparam  ofs_w = `NF_REGION_LSB,
                pad_w = `NF_DATA_WIDTH - gpio_w;

    logic   [gpio_w-1 : 0]  gpi_meta;                   // first sync stage
    logic   [gpio_w-1 : 0]  gpi_sync;                   // second sync stage
    logic   [ofs_w-1  : 0]  ofs;                        // offset inside region
    logic   [0 : 0]         acc;                        // first cycle of an access

    assign ofs = adr_i[ofs_w-1 : 0];
    assign acc = stb_i & ~ack_o;

    always_ff @(posedge clk, negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpi_meta <= '0;
            gpi_sync <= '0;
            gpio_o   <= '0;
            gpio_d_o <= '0;
            ack_o    <= 1'b0;
        end else begin
            gpi_meta <= gpio_i;
            gpi_sync <= gpi_meta;
            ack_o    <= acc;
            if (acc & we_i) begin
                case (ofs)
                    `NF_GPIO_GPO_OFS : gpio_o   <= dat_i[gpio_w-1 : 0];
                    `NF_GPIO_GPD_OFS : gpio_d_o <= dat_i[gpio_w-1 : 0];
                    default          : ;        // gpi and holes are read only
                endcase
            end
        end
    end

    // read mux, zero extended
    always_ff @(posedge clk) begin
        if (acc) begin
            case (ofs)
                `NF_GPIO_GPI_OFS : dat_o <= {{pad_w{1'b0}}, gpi_sync};
                `NF_GPIO_GPO_OFS : dat_o <= {{pad_w{1'b0}}, gpio_o};
                `NF_GPIO_GPD_OFS : dat_o <= {{pad_w{1'b0}}, gpio_d_o};
                default          : dat_o <= '0;
            endcase
        end
    end

endmodule : nf_wb_gpio

// ==== hw/nf_wb_pwm.sv ====
`timescale 1ns/1ps
`include "nf_cfg.svh"

module nf_wb_pwm
    import nf_pkg::*;
#(
    parameter   pwm_w = `NF_PWM_WIDTH                   // counter width
)
(
    // clock and reset
    input   logic   [0 : 0]     clk,                    // clock
    input   logic   [0 : 0]     rst_n_i,                // async reset, active low
    // slave side
    input   logic   [0 : 0]     stb_i,                  // select from decoder
    input   logic   [0 : 0]     we_i,                   // write enable
    input   addr_t              adr_i,                  // byte address
    input   data_t              dat_i,                  // write data
    output  data_t              dat_o,                  // read data
    output  logic   [0 : 0]     ack_o,                  // one cycle ack
    // pwm side
    output  logic   [0 : 0]     pwm_o                   // registered pwm output
);

    localparam  ofs_w = `NF_REGION_LSB,
                pad_w = `NF_DATA_WIDTH - pwm_w;

    logic   [pwm_w-1 : 0]   duty_r;                     // bus visible duty
    logic   [pwm_w-1 : 0]   duty_sh;                    // duty used by compare
    logic   [pwm_w-1 : 0]   cnt;                        // free running counter
    logic   [ofs_w-1 : 0]   ofs;                        // offset inside region
    logic   [0 : 0]         acc;                        // first cycle of an access
    logic   [0 : 0]         wrap;                       // counter at its last value

    assign ofs  = adr_i[ofs_w-1 : 0];
    assign acc  = stb_i & ~ack_o;
    assign wrap = (cnt == '1);

    // bus registers
    always_ff @(posedge clk, negedge rst_n_i) begin
        if (!rst_n_i) begin
            duty_r <= '0;
            ack_o  <= 1'b0;
        end else begin
            ack_o <= acc;
            if (acc & we_i & (ofs == `NF_PWM_DUTY_OFS)) begin
                duty_r <= dat_i[pwm_w-1 : 0];   // upper bits dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            dat_o <= (ofs == `NF_PWM_DUTY_OFS) ? {{pad_w{1'b0}}, duty_r} : '0;
        end
    end

    // pwm core
    always_ff @(posedge clk, negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt     <= '0;
            duty_sh <= '0;
            pwm_o   <= 1'b0;
        end else begin
            cnt   <= cnt + 1'b1;                // wraps naturally
            pwm_o <= (cnt < duty_sh);           // one cycle behind the counter
            if (wrap) begin
                duty_sh <= duty_r;              // new duty from next period on
            end
        end
    end

endmodule : nf_wb_pwm

// ==== hw/nf_periph_top.sv ====
`timescale 1ns/1ps
`include "nf_cfg.svh"

module nf_periph_top
(
    // clock and reset
    input   logic   [0 : 0]                     clk,        // clock
    input   logic   [0 : 0]                     rst_n_i,    // async reset, active low
    // wishbone slave port
    input   logic   [0 : 0]                     wb_cyc_i,   // bus cycle
    input   logic   [0 : 0]                     wb_stb_i,   // bus strobe
    input   logic   [0 : 0]                     wb_we_i,    // write enable
    input   logic   [`NF_ADDR_WIDTH-1   : 0]    wb_adr_i,   // byte address
    input   logic   [`NF_DATA_WIDTH-1   : 0]    wb_dat_i,   // write data
    input   logic   [`NF_DATA_WIDTH/8-1 : 0]    wb_sel_i,   // byte lanes
    output  logic   [`NF_DATA_WIDTH-1   : 0]    wb_dat_o,   // read data
    output  logic   [0 : 0]                     wb_ack_o,   // access done
    output  logic   [0 : 0]                     wb_err_o,   // unmapped access
    // gpio side
    input   logic   [`NF_GPIO_WIDTH-1   : 0]    gpio_i,     // gpio input
    output  logic   [`NF_GPIO_WIDTH-1   : 0]    gpio_o,     // gpio output
    output  logic   [`NF_GPIO_WIDTH-1   : 0]    gpio_d_o,   // gpio direction
    // pwm side
    output  logic   [0 : 0]                     pwm_o       // pwm output
);

    localparam  gpio_w = `NF_GPIO_WIDTH,
                pwm_w  = `NF_PWM_WIDTH,
                depth  = `NF_RAM_DEPTH,
                data_w = `NF_DATA_WIDTH;

    // per slave strobes
    logic   [0 : 0]             ram_stb;        // ram select
    logic   [0 : 0]             gpio_stb;       // gpio select
    logic   [0 : 0]             pwm_stb;        // pwm select
    // slave returns
    logic   [0 : 0]             ram_ack;        // ram ack
    logic   [0 : 0]             gpio_ack;       // gpio ack
    logic   [0 : 0]             pwm_ack;        // pwm ack
    logic   [data_w-1 : 0]      ram_dat;        // ram read data
    logic   [data_w-1 : 0]      gpio_dat;       // gpio read data
    logic   [data_w-1 : 0]      pwm_dat;        // pwm read data

    // address decoder and return mux
    nf_wb_decoder
    nf_wb_decoder_0
    (
        .clk            ( clk           ),      // clock
        .rst_n_i        ( rst_n_i       ),      // reset
        .wb_cyc_i       ( wb_cyc_i      ),      // bus cycle
        .wb_stb_i       ( wb_stb_i      ),      // bus strobe
        .wb_adr_i       ( wb_adr_i      ),      // address
        .ram_stb_o      ( ram_stb       ),      // ram select
        .gpio_stb_o     ( gpio_stb      ),      // gpio select
        .pwm_stb_o      ( pwm_stb       ),      // pwm select
        .ram_ack_i      ( ram_ack       ),      // ram ack
        .gpio_ack_i     ( gpio_ack      ),      // gpio ack
        .pwm_ack_i      ( pwm_ack       ),      // pwm ack
        .ram_dat_i      ( ram_dat       ),      // ram data
        .gpio_dat_i     ( gpio_dat      ),      // gpio data
        .pwm_dat_i      ( pwm_dat       ),      // pwm data
        .wb_dat_o       ( wb_dat_o      ),      // read data
        .wb_ack_o       ( wb_ack_o      ),      // ack
        .wb_err_o       ( wb_err_o      )       // error
    );

    // word ram
    nf_wb_ram
    #(
        .depth          ( depth         )
    )
    nf_wb_ram_0
    (
        .clk            ( clk           ),      // clock
        .rst_n_i        ( rst_n_i       ),      // reset
        .stb_i          ( ram_stb       ),      // select
        .we_i           ( wb_we_i       ),      // write enable
        .adr_i          ( wb_adr_i      ),      // address
        .dat_i          ( wb_dat_i      ),      // write data
        .sel_i          ( wb_sel_i      ),      // byte lanes
        .dat_o          ( ram_dat       ),      // read data
        .ack_o          ( ram_ack       )       // ack
    );

    // gpio port
    nf_wb_gpio
    #(
        .gpio_w         ( gpio_w        )
    )
    nf_wb_gpio_0
    (
        .clk            ( clk           ),      // clock
        .rst_n_i        ( rst_n_i       ),      // reset
        .stb_i          ( gpio_stb      ),      // select
        .we_i           ( wb_we_i       ),      // write enable
        .adr_i          ( wb_adr_i      ),      // address
        .dat_i          ( wb_dat_i      ),      // write data
        .dat_o          ( gpio_dat      ),      // read data
        .ack_o          ( gpio_ack      ),      // ack
        .gpio_i         ( gpio_i        ),      // input pins
        .gpio_o         ( gpio_o        ),      // output pins
        .gpio_d_o       ( gpio_d_o      )       // direction
    );

    // pwm generator
    nf_wb_pwm
    #(
        .pwm_w          ( pwm_w         )
    )
    nf_wb_pwm_0
    (
        .clk            ( clk           ),      // clock
        .rst_n_i        ( rst_n_i       ),      // reset
        .stb_i          ( pwm_stb       ),      // select
        .we_i           ( wb_we_i       ),      // write enable
        .adr_i          ( wb_adr_i      ),      // address
        .dat_i          ( wb_dat_i      ),      // write data
        .dat_o          ( pwm_dat       ),      // read data
        .ack_o          ( pwm_ack       ),      // ack
        .pwm_o          ( pwm_o         )       // pwm output
    );

endmodule : nf_periph_top

// ==== verification/nf_periph_asserts.sv ====
`timescale 1ns/1ps

module nf_periph_asserts
(
    input   logic   [0 : 0]     clk,        // dut clock
    input   logic   [0 : 0]     rst_n_i,    // dut reset active low
    input   logic   [0 : 0]     cyc_i,      // bus cycle
    input   logic   [0 : 0]     stb_i,      // bus strobe
    input   logic   [0 : 0]     ack_i,      // dut ack
    input   logic   [0 : 0]     err_i       // dut err
);

    int     fails = 0;                      // assertion failures so far

    ack_err_excl : assert property (@(posedge clk) disable iff (!rst_n_i) !(ack_i && err_i))
        else begin
            fails++;
            $error("ack and err high in the same cycle");
        end
    // a response needs a request on the previous edge
    resp_after_req : assert property (@(posedge clk) disable iff (!rst_n_i)
        (ack_i || err_i) |-> $past(cyc_i && stb_i))
        else begin
            fails++;
            $error("response without a preceding request");
        end
    ack_pulse : assert property (@(posedge clk) disable iff (!rst_n_i) ack_i |=> !ack_i)
        else begin
            fails++;
            $error("ack longer than one cycle");
        end
    err_pulse : assert property (@(posedge clk) disable iff (!rst_n_i) err_i |=> !err_i)
        else begin
            fails++;
            $error("err longer than one cycle");
        end
    quiet_in_reset : assert property (@(posedge clk) !rst_n_i |-> !(ack_i || err_i))
        else begin
            fails++;
            $error("response while in reset");
        end

endmodule : nf_periph_asserts

bind nf_periph_top nf_periph_asserts asserts_0
(
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .cyc_i      ( wb_cyc_i  ),
    .stb_i      ( wb_stb_i  ),
    .ack_i      ( wb_ack_o  ),
    .err_i      ( wb_err_o  )
);

// ==== verification/nf_periph_checker.sv ====
`timescale 1ns/1ps
`include "nf_cfg.svh"

module nf_periph_checker
    import nf_pkg::*;
(
    input   logic   [0 : 0]     clk,            // clock
    input   logic   [0 : 0]     rst_n_i,        // dut reset
    input   logic   [0 : 0]     we_i,           // bus write enable
    input   addr_t              adr_i,          // bus address
    input   data_t              wdat_i,         // bus write data
    input   data_t              rdat_i,         // dut read data
    input   logic   [0 : 0]     ack_i,          // dut ack
    input   logic   [0 : 0]     err_i,          // dut err
    input   gpio_t              gpo_i,          // dut gpio_o
    input   gpio_t              gpd_i,          // dut gpio_d_o
    input   logic   [0 : 0]     pwm_i,          // dut pwm_o
    input   logic   [0 : 0]     exp_valid_i,    // access in flight
    input   data_t              exp_dat_i,      // expected read data
    input   logic   [0 : 0]     exp_err_i,      // err expected, no ack
    output  int                 err_cnt_o       // errors so far
);

    localparam  ofs_w  = `NF_REGION_LSB,
                period = 1 << `NF_PWM_WIDTH;

    gpio_t                  gpo_m;              // expected gpio_o
    gpio_t                  gpd_m;              // expected gpio_d_o
    duty_t                  duty_m;             // duty of the period being measured
    duty_t                  duty_p;             // written duty, waits for its period
    int                     pend_per;           // first period of duty_p, -1 none
    int                     cyc;                // cycles since reset, follows pwm counter
    int                     high;               // pwm high samples in this period
    int                     errs = 0;
    logic   [3 : 0]         region;
    logic   [ofs_w-1 : 0]   ofs;

    assign region    = adr_i[`NF_REGION_MSB : `NF_REGION_LSB];
    assign ofs       = adr_i[ofs_w-1 : 0];
    assign err_cnt_o = errs;

    task automatic flag_value(input string name, input data_t exp_v, input data_t got_v);
        $display("Error %s exp 0x%0h got 0x%0h", name, exp_v, got_v);
        errs++;
    endtask

    task automatic flag_fault(input string what);
        $display("%s at %0t", what, $time);
        errs++;
    endtask

    // sampled mid cycle, away from the edges
    always @(negedge clk) begin
        if (!rst_n_i) begin
            gpo_m    = '0;
            gpd_m    = '0;
            duty_m   = '0;
            pend_per = -1;
            cyc      = 0;
            high     = 0;
        end else begin
            if (cyc > 0) begin                  // pwm_o shows the previous count
                if ((cyc - 1) % period == 0 && pend_per >= 0 &&
                    pend_per <= (cyc - 1) / period) begin
                    duty_m   = duty_p;          // new period picks up the shadow
                    pend_per = -1;
                end
                high += pwm_i;
                if ((cyc - 1) % period == period - 1) begin
                    if (high != duty_m)
                        flag_value("pwm_o high count", data_t'(duty_m), data_t'(high));
                    high = 0;
                end
            end
            if ((ack_i || err_i) && !exp_valid_i)
                flag_fault("response with no access pending");
            else if (ack_i && exp_err_i)
                flag_fault("ack on an unmapped access, err expected");
            else if (err_i && !exp_err_i)
                flag_fault("err on a mapped access");
            else if (ack_i && !we_i && rdat_i !== exp_dat_i)
                flag_value("wb_dat_o", exp_dat_i, rdat_i);
            // register mirrors, only acked writes count
            if (ack_i && we_i && region == `NF_REGION_GPIO && ofs == `NF_GPIO_GPO_OFS)
                gpo_m = gpio_t'(wdat_i);
            if (ack_i && we_i && region == `NF_REGION_GPIO && ofs == `NF_GPIO_GPD_OFS)
                gpd_m = gpio_t'(wdat_i);
            if (ack_i && we_i && region == `NF_REGION_PWM && ofs == `NF_PWM_DUTY_OFS) begin
                duty_p   = duty_t'(wdat_i);
                pend_per = cyc / period + 1;    // takes over after the next wrap
            end
            cyc++;
        end
        if (gpo_i !== gpo_m)
            flag_value("gpio_o", data_t'(gpo_m), data_t'(gpo_i));
        if (gpd_i !== gpd_m)
            flag_value("gpio_d_o", data_t'(gpd_m), data_t'(gpd_i));
    end

endmodule : nf_periph_checker

// ==== verification/nf_periph_tb.sv ====
`timescale 1ns/1ps
`include "nf_cfg.svh"

module nf_periph_tb
    import nf_pkg::*;
();

    localparam  rows_max = 64;
    localparam  addr_t          gpio_base = addr_t'(`NF_REGION_GPIO) << `NF_REGION_LSB;
    localparam  addr_t          pwm_base  = addr_t'(`NF_REGION_PWM) << `NF_REGION_LSB;
    localparam  logic [15 : 0]  lane_pats = 16'hc961;      // partial write selects
    localparam  logic [23 : 0]  duty_seq  = 24'h00ff40;    // 64, 255, 0

    logic   [0 : 0]     clk = 1'b0;
    logic   [0 : 0]     rst_n = 1'b1;       // falls at time zero
    logic   [0 : 0]     wb_cyc;
    logic   [0 : 0]     wb_stb;
    logic   [0 : 0]     wb_we;
    addr_t              wb_adr;
    data_t              wb_wdat;
    sel_t               wb_sel;
    data_t              wb_rdat;
    logic   [0 : 0]     wb_ack;
    logic   [0 : 0]     wb_err;
    gpio_t              gpio_in;
    gpio_t              gpio_out;
    gpio_t              gpio_dir;
    logic   [0 : 0]     pwm_out;
    logic   [0 : 0]     exp_valid;          // expectation presented to checker
    data_t              exp_dat;
    logic   [0 : 0]     exp_err;
    int                 err_cnt;            // from the checker
    int                 cycles = 0;
    int                 limit;              // timeout in cycles

    // stimulus table with one entry per bus access
    logic   [0 : 0]     t_we    [rows_max];
    addr_t              t_adr   [rows_max];
    data_t              t_dat   [rows_max];
    sel_t               t_sel   [rows_max];
    data_t              t_exp   [rows_max];
    logic   [0 : 0]     t_err   [rows_max];
    int                 t_wait  [rows_max]; // idle cycles after the access
    gpio_t              t_pins  [rows_max]; // gpio_i level during the access
    int                 rows = 0;
    gpio_t              cur_pins = '0;
    data_t              ram_m   [`NF_RAM_DEPTH];    // expected ram words

    always #20 clk = ~clk;

    nf_periph_top uut (
        .clk(clk), .rst_n_i(rst_n), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat), .wb_sel_i(wb_sel),
        .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
        .gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_d_o(gpio_dir), .pwm_o(pwm_out)
    );

    nf_periph_checker checker_0 (
        .clk(clk), .rst_n_i(rst_n), .we_i(wb_we), .adr_i(wb_adr), .wdat_i(wb_wdat),
        .rdat_i(wb_rdat), .ack_i(wb_ack), .err_i(wb_err), .gpo_i(gpio_out),
        .gpd_i(gpio_dir), .pwm_i(pwm_out), .exp_valid_i(exp_valid),
        .exp_dat_i(exp_dat), .exp_err_i(exp_err), .err_cnt_o(err_cnt)
    );

    function automatic data_t merge_lanes(input data_t old_w, input data_t new_w, input sel_t sel);
        data_t res;
        res = old_w;
        for (int i = 0; i < $bits(sel_t); i++)
            if (sel[i])
                res[i*8 +: 8] = new_w[i*8 +: 8];
        return res;
    endfunction

    task automatic add_row(input logic we, input addr_t adr, input data_t dat, input sel_t sel,
                           input data_t exp_v, input logic err, input int idle);
        t_we[rows]   = we;
        t_adr[rows]  = adr;
        t_dat[rows]  = dat;
        t_sel[rows]  = sel;
        t_exp[rows]  = exp_v;
        t_err[rows]  = err;
        t_wait[rows] = idle;
        t_pins[rows] = cur_pins;
        rows++;
    endtask

    task automatic ram_write(input int word, input data_t dat, input sel_t sel);
        ram_m[word] = merge_lanes(ram_m[word], dat, sel);
        add_row(1'b1, addr_t'(word) << 2, dat, sel, '0, 1'b0, 0);
    endtask

    task automatic ram_read(input int word);
        add_row(1'b0, addr_t'(word) << 2, '0, '1, ram_m[word], 1'b0, 0);
    endtask

    task automatic build_table();
        add_row(1'b0, gpio_base + `NF_GPIO_GPO_OFS, '0, '1, '0, 1'b0, 0);   // reset values
        add_row(1'b0, gpio_base + `NF_GPIO_GPD_OFS, '0, '1, '0, 1'b0, 0);
        add_row(1'b0, pwm_base + `NF_PWM_DUTY_OFS, '0, '1, '0, 1'b0, 0);
        add_row(1'b0, gpio_base + `NF_GPIO_GPI_OFS, '0, '1, '0, 1'b0, 0);
        for (int i = 0; i < 8; i++)
            ram_write(i * 37 % 256, data_t'($urandom), 4'hf);
        for (int i = 0; i < 8; i++)
            ram_read(i * 37 % 256);
        for (int i = 0; i < 4; i++) begin               // byte lanes merge with old word
            ram_write(i * 37 % 256, data_t'($urandom), lane_pats[i*4 +: 4]);
            ram_read(i * 37 % 256);
        end
        add_row(1'b0, 32'h400 | (37 << 2), '0, '1, ram_m[37], 1'b0, 0);  // wraps at depth
        add_row(1'b1, gpio_base + `NF_GPIO_GPO_OFS, 32'hdeadbea5, '1, '0, 1'b0, 0);
        add_row(1'b1, gpio_base + `NF_GPIO_GPD_OFS, 32'h0000013c, '1, '0, 1'b0, 0);
        add_row(1'b0, gpio_base + `NF_GPIO_GPO_OFS, '0, '1, 32'ha5, 1'b0, 0);
        add_row(1'b0, gpio_base + `NF_GPIO_GPD_OFS, '0, '1, 32'h3c, 1'b0, 0);
        add_row(1'b1, gpio_base + `NF_GPIO_GPI_OFS, 32'hff, '1, '0, 1'b0, 0);   // read only
        add_row(1'b1, gpio_base + 'hc, 32'h77, '1, '0, 1'b0, 0);                // hole
        add_row(1'b0, gpio_base + 'hc, '0, '1, '0, 1'b0, 0);
        add_row(1'b0, gpio_base + `NF_GPIO_GPO_OFS, '0, '1, 32'ha5, 1'b0, 0);
        cur_pins = 8'h5a;
        add_row(1'b0, gpio_base + `NF_GPIO_GPI_OFS, '0, '1, 32'h5a, 1'b0, 0);
        cur_pins = 8'hc3;
        add_row(1'b0, gpio_base + `NF_GPIO_GPI_OFS, '0, '1, 32'hc3, 1'b0, 0);
        for (int i = 0; i < 3; i++) begin               // long idle covers two full periods
            add_row(1'b1, pwm_base, {24'h5a5a5a, duty_seq[i*8 +: 8]}, '1, '0, 1'b0, 0);
            add_row(1'b0, pwm_base, '0, '1, data_t'(duty_seq[i*8 +: 8]), 1'b0, 560);
        end
        for (int r = 3; r < 16; r++)
            add_row(r[0], (addr_t'(r) << `NF_REGION_LSB) | (r[1] ? 'h94 : 'h4), '1, '1, '0,
                    1'b1, 0);
        ram_read(37);
        add_row(1'b0, gpio_base + `NF_GPIO_GPO_OFS, '0, '1, 32'ha5, 1'b0, 0);
    endtask

    task automatic run_row(input int r);
        if (t_pins[r] !== gpio_in) begin
            @(posedge clk);
            gpio_in <= t_pins[r];
            repeat (3) @(posedge clk);                  // through the synchronizer
        end
        @(posedge clk);
        wb_cyc    <= 1'b1;
        wb_stb    <= 1'b1;
        wb_we     <= t_we[r];
        wb_adr    <= t_adr[r];
        wb_wdat   <= t_dat[r];
        wb_sel    <= t_sel[r];
        exp_valid <= 1'b1;
        exp_dat   <= t_exp[r];
        exp_err   <= t_err[r];
        do @(negedge clk); while (!(wb_ack || wb_err));
        @(posedge clk);
        wb_cyc    <= 1'b0;
        wb_stb    <= 1'b0;
        exp_valid <= 1'b0;
        repeat (t_wait[r]) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: bus access never completed");
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h626eaf1c));
        rst_n     <= 1'b0;                              // edge seen by every reset flop
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_wdat   = '0;
        wb_sel    = '0;
        gpio_in   = '0;
        exp_valid = 1'b0;
        exp_dat   = '0;
        exp_err   = 1'b0;
        build_table();
        limit = 16 + 64;                                // reset plus margin
        for (int r = 0; r < rows; r++)
            limit += 11 + t_wait[r];
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < rows; r++)
            run_row(r);
        repeat (4) @(posedge clk);
        $display("summary: %0d accesses, %0d check errors, %0d assertion failures",
                 rows, err_cnt, uut.asserts_0.fails);
        if (err_cnt == 0 && uut.asserts_0.fails == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule : nf_periph_tb

// ==== all.f ====
+incdir+hw
hw/nf_pkg.sv
hw/nf_wb_decoder.sv
hw/nf_wb_ram.sv
hw/nf_wb_gpio.sv
hw/nf_wb_pwm.sv
hw/nf_periph_top.sv
verification/nf_periph_asserts.sv
verification/nf_periph_checker.sv
verification/nf_periph_tb.sv

// ==== Bender.yml ====
package:
  name: nf_periph

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/nf_pkg.sv
      - hw/nf_wb_decoder.sv
      - hw/nf_wb_ram.sv
      - hw/nf_wb_gpio.sv
      - hw/nf_wb_pwm.sv
      - hw/nf_periph_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/nf_periph_asserts.sv
      - verification/nf_periph_checker.sv
      - verification/nf_periph_tb.sv
